// File: src/ex_pkg.sv
package ex_pkg;

    // executed operation, numbering is shared with the issue side
    typedef enum logic [5:0] {
        OP_NOP       = 6'd0,
        OP_ADD       = 6'd1,
        OP_SUB       = 6'd2,
        OP_SLT       = 6'd3,
        OP_SLTU      = 6'd4,
        OP_AND       = 6'd5,
        OP_OR        = 6'd6,
        OP_XOR       = 6'd7,
        OP_NOR       = 6'd8,
        OP_SLL       = 6'd9,
        OP_SRL       = 6'd10,
        OP_SRA       = 6'd11,
        OP_PCADDU12I = 6'd12,
        OP_DIV       = 6'd13,
        OP_DIVU      = 6'd14,
        OP_MOD       = 6'd15,
        OP_MODU      = 6'd16,
        OP_BEQ       = 6'd17,
        OP_BNE       = 6'd18,
        OP_BLT       = 6'd19,
        OP_BGE       = 6'd20,
        OP_BLTU      = 6'd21,
        OP_BGEU      = 6'd22,
        OP_JIRL      = 6'd23,
        OP_LDB       = 6'd24,
        OP_LDBU      = 6'd25,
        OP_LDH       = 6'd26,
        OP_LDHU      = 6'd27,
        OP_LDW       = 6'd28,
        OP_STB       = 6'd29,
        OP_STH       = 6'd30,
        OP_STW       = 6'd31
    } ex_op_e;

    typedef enum logic [1:0] {
        UNIT_ALU    = 2'd0,
        UNIT_DIV    = 2'd1,
        UNIT_BRANCH = 2'd2,
        UNIT_MEM    = 2'd3
    } ex_unit_e;

    // ALE for data access, ADEF for a bad fetch target
    typedef enum logic [1:0] {
        EXC_NONE = 2'd0,
        EXC_ALE  = 2'd1,
        EXC_ADEF = 2'd2
    } exc_cause_e;

    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } mem_size_e;

endpackage

// File: src/ex_decode.sv
`timescale 1ns/100ps

module ex_decode (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 issue_valid_i,
    input  ex_pkg::ex_op_e       op_i,
    input  logic [31:0]          pc_i,
    input  logic [31:0]          src1_i,
    input  logic [31:0]          src2_i,
    input  logic [31:0]          imm_i,
    input  logic                 pred_taken_i,
    input  logic [31:0]          pred_target_i,
    input  logic                 retire_i,
    output logic                 issue_ready_o,
    output logic                 start_o,
    output ex_pkg::ex_unit_e     unit_o,
    output ex_pkg::ex_op_e       op_o,
    output logic [31:0]          pc_o,
    output logic [31:0]          src1_o,
    output logic [31:0]          src2_o,
    output logic [31:0]          imm_o,
    output logic                 pred_taken_o,
    output logic [31:0]          pred_target_o
);
    import ex_pkg::*;

    logic busy_q;
    logic accepted_q;
    logic accept;

    assign issue_ready_o = !busy_q;
    assign accept = issue_valid_i && !busy_q;

    // busy from acceptance until the cycle after hand-off
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            accepted_q <= 1'b0;
            start_o <= 1'b0;
        end else begin
            accepted_q <= accept;
            start_o <= accepted_q;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (retire_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    // fields stay put for the whole instruction
    always_ff @(posedge clk) begin
        if (accept) begin
            op_o <= op_i;
            pc_o <= pc_i;
            src1_o <= src1_i;
            src2_o <= src2_i;
            imm_o <= imm_i;
            pred_taken_o <= pred_taken_i;
            pred_target_o <= pred_target_i;
        end
    end

    always_comb begin
        case (op_o)
            OP_DIV, OP_DIVU, OP_MOD, OP_MODU: unit_o = UNIT_DIV;
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_JIRL: unit_o = UNIT_BRANCH;
            OP_LDB, OP_LDBU, OP_LDH, OP_LDHU, OP_LDW, OP_STB, OP_STH, OP_STW: unit_o = UNIT_MEM;
            default: unit_o = UNIT_ALU;
        endcase
    end

endmodule

// File: src/int_alu.sv
`timescale 1ns/100ps

module int_alu #(
    parameter int DATA_W = 32
) (
    input  ex_pkg::ex_op_e       op_i,
    input  logic [31:0]          pc_i,
    input  logic [DATA_W-1:0]    a_i,
    input  logic [DATA_W-1:0]    b_i,
    input  logic [31:0]          imm_i,
    output logic [DATA_W-1:0]    result_o
);
    import ex_pkg::*;

    logic [4:0]  shamt;
    logic [31:0] pc_rel;
    logic        lt_s;
    logic        lt_u;

    assign shamt = b_i[4:0];
    assign pc_rel = pc_i + (imm_i << 12);
    assign lt_s = $signed(a_i) < $signed(b_i);
    assign lt_u = a_i < b_i;

    always_comb begin
        case (op_i)
            OP_ADD:       result_o = a_i + b_i;
            OP_SUB:       result_o = a_i - b_i;
            OP_SLT:       result_o = {{(DATA_W-1){1'b0}}, lt_s};
            OP_SLTU:      result_o = {{(DATA_W-1){1'b0}}, lt_u};
            OP_AND:       result_o = a_i & b_i;
            OP_OR:        result_o = a_i | b_i;
            OP_XOR:       result_o = a_i ^ b_i;
            OP_NOR:       result_o = ~(a_i | b_i);
            OP_SLL:       result_o = a_i << shamt;
            OP_SRL:       result_o = a_i >> shamt;
            // arithmetic shift keeps the sign
            OP_SRA:       result_o = $signed(a_i) >>> shamt;
            OP_PCADDU12I: result_o = DATA_W'(pc_rel);
            default:      result_o = '0;
        endcase
    end

endmodule

// File: src/iter_divider.sv
`timescale 1ns/100ps

module iter_divider #(
    parameter int DATA_W = 32
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 start_i,
    input  ex_pkg::ex_op_e       op_i,
    input  logic [DATA_W-1:0]    dividend_i,
    input  logic [DATA_W-1:0]    divisor_i,
    output logic                 done_o,
    output logic [DATA_W-1:0]    result_o
);
    import ex_pkg::*;

    localparam int CNT_W = $clog2(DATA_W + 1);

    logic                is_signed;
    logic                is_div;
    logic                neg_a;
    logic                neg_b;
    logic [DATA_W-1:0]   mag_a;
    logic [DATA_W-1:0]   mag_b;
    logic [DATA_W-1:0]   quo_q;
    logic [DATA_W-1:0]   quo_in;
    logic [DATA_W-1:0]   quo_next;
    logic [DATA_W-1:0]   rem_q;
    logic [DATA_W-1:0]   rem_in;
    logic [DATA_W-1:0]   rem_next;
    logic [DATA_W:0]     shifted;
    logic [DATA_W+1:0]   diff;
    logic [DATA_W-1:0]   quo_fix;
    logic [DATA_W-1:0]   rem_fix;
    logic [CNT_W-1:0]    cnt_q;
    logic                busy_q;

    assign is_signed = (op_i == OP_DIV) || (op_i == OP_MOD);
    assign is_div = (op_i == OP_DIV) || (op_i == OP_DIVU);
    assign neg_a = is_signed && dividend_i[DATA_W-1];
    assign neg_b = is_signed && divisor_i[DATA_W-1];
    assign mag_a = neg_a ? -dividend_i : dividend_i;
    assign mag_b = neg_b ? -divisor_i : divisor_i;

    // first step runs on the fresh operands in the start cycle
    assign rem_in = start_i ? '0 : rem_q;
    assign quo_in = start_i ? mag_a : quo_q;
    assign shifted = {rem_in, quo_in[DATA_W-1]};
    assign diff = {1'b0, shifted} - {2'b00, mag_b};
    assign rem_next = diff[DATA_W+1] ? shifted[DATA_W-1:0] : diff[DATA_W-1:0];
    assign quo_next = {quo_in[DATA_W-2:0], ~diff[DATA_W+1]};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            done_o <= 1'b0;
            cnt_q <= '0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                busy_q <= 1'b1;
                cnt_q <= CNT_W'(DATA_W - 1);
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == CNT_W'(1)) begin
                    busy_q <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i || busy_q) begin
            rem_q <= rem_next;
            quo_q <= quo_next;
        end
    end

    // remainder follows the dividend sign
    assign quo_fix = (neg_a ^ neg_b) ? -quo_q : quo_q;
    assign rem_fix = neg_a ? -rem_q : rem_q;

    always_comb begin
        if (divisor_i == '0) begin
            result_o = is_div ? '1 : dividend_i;
        end else begin
            result_o = is_div ? quo_fix : rem_fix;
        end
    end

endmodule

// File: src/branch_unit.sv
`timescale 1ns/100ps

module branch_unit (
    input  ex_pkg::ex_op_e       op_i,
    input  logic [31:0]          pc_i,
    input  logic [31:0]          a_i,
    input  logic [31:0]          b_i,
    input  logic [31:0]          imm_i,
    input  logic                 pred_taken_i,
    input  logic [31:0]          pred_target_i,
    output logic [31:0]          link_o,
    output logic                 redirect_o,
    output logic [31:0]          redirect_pc_o,
    output ex_pkg::exc_cause_e   exc_cause_o
);
    import ex_pkg::*;

    logic [31:0] target;
    logic [31:0] seq_pc;
    logic        taken;
    logic        target_bad;

    always_comb begin
        target = pc_i + imm_i;
        case (op_i)
            OP_BEQ:  taken = a_i == b_i;
            OP_BNE:  taken = a_i != b_i;
            OP_BLT:  taken = $signed(a_i) < $signed(b_i);
            OP_BGE:  taken = $signed(a_i) >= $signed(b_i);
            OP_BLTU: taken = a_i < b_i;
            OP_BGEU: taken = a_i >= b_i;
            OP_JIRL: begin
                taken = 1'b1;
                target = a_i + imm_i;
            end
            default: taken = 1'b0;
        endcase
    end

    assign seq_pc = pc_i + 32'd4;
    assign link_o = seq_pc;
    assign target_bad = taken && (target[1:0] != 2'b00);
    assign exc_cause_o = target_bad ? EXC_ADEF : EXC_NONE;

    // wrong direction, or taken to a different place than predicted
    assign redirect_o = !target_bad &&
        ((taken != pred_taken_i) || (taken && (target != pred_target_i)));
    assign redirect_pc_o = taken ? target : seq_pc;

endmodule

// File: src/lsu_wb_master.sv
`timescale 1ns/100ps

module lsu_wb_master (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 start_i,
    input  ex_pkg::ex_op_e       op_i,
    input  logic [31:0]          base_i,
    input  logic [31:0]          data_i,
    input  logic [31:0]          imm_i,
    output logic                 wb_cyc_o,
    output logic                 wb_stb_o,
    output logic                 wb_we_o,
    output logic [29:0]          wb_adr_o,
    output logic [31:0]          wb_dat_o,
    output logic [3:0]           wb_sel_o,
    input  logic [31:0]          wb_dat_i,
    input  logic                 wb_ack_i,
    output logic                 done_o,
    output logic [31:0]          load_data_o,
    output ex_pkg::exc_cause_e   exc_cause_o
);
    import ex_pkg::*;

    logic [31:0] addr;
    mem_size_e   size;
    logic        is_store;
    logic        is_signed;
    logic        misaligned;
    logic        go;
    logic        active_q;
    logic        done_q;
    logic        ack_seen;
    logic [31:0] lane;
    logic [31:0] ext;
    logic [31:0] load_q;

    assign addr = base_i + imm_i;

    always_comb begin
        size = SIZE_W;
        is_store = 1'b0;
        is_signed = 1'b0;
        case (op_i)
            OP_LDB: begin
                size = SIZE_B;
                is_signed = 1'b1;
            end
            OP_LDBU: size = SIZE_B;
            OP_LDH: begin
                size = SIZE_H;
                is_signed = 1'b1;
            end
            OP_LDHU: size = SIZE_H;
            OP_STB: begin
                size = SIZE_B;
                is_store = 1'b1;
            end
            OP_STH: begin
                size = SIZE_H;
                is_store = 1'b1;
            end
            OP_STW: is_store = 1'b1;
            default: size = SIZE_W;
        endcase
    end

    // store data replicated on all lanes, select picks the live ones
    always_comb begin
        case (size)
            SIZE_B: begin
                wb_sel_o = 4'b0001 << addr[1:0];
                wb_dat_o = {4{data_i[7:0]}};
            end
            SIZE_H: begin
                wb_sel_o = addr[1] ? 4'b1100 : 4'b0011;
                wb_dat_o = {2{data_i[15:0]}};
            end
            default: begin
                wb_sel_o = 4'b1111;
                wb_dat_o = data_i;
            end
        endcase
    end

    assign misaligned = ((size == SIZE_H) && addr[0]) ||
                        ((size == SIZE_W) && (addr[1:0] != 2'b00));
    assign go = start_i && !misaligned;
    assign wb_cyc_o = go || active_q;
    assign wb_stb_o = wb_cyc_o;
    assign wb_we_o = is_store;
    assign wb_adr_o = addr[31:2];
    assign ack_seen = wb_cyc_o && wb_ack_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            active_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= ack_seen;
            if (ack_seen) begin
                active_q <= 1'b0;
            end else if (go) begin
                active_q <= 1'b1;
            end
        end
    end

    // addressed lanes moved down, then extended
    assign lane = wb_dat_i >> {addr[1:0], 3'b000};

    always_comb begin
        case (size)
            SIZE_B:  ext = {{24{is_signed && lane[7]}}, lane[7:0]};
            SIZE_H:  ext = {{16{is_signed && lane[15]}}, lane[15:0]};
            default: ext = lane;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ack_seen) begin
            load_q <= is_store ? 32'd0 : ext;
        end
    end

    assign done_o = done_q || (start_i && misaligned);
    assign load_data_o = misaligned ? 32'd0 : load_q;
    assign exc_cause_o = misaligned ? EXC_ALE : EXC_NONE;

endmodule

// File: src/ex_result.sv
`timescale 1ns/100ps

module ex_result #(
    parameter int DATA_W = 32
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 start_i,
    input  ex_pkg::ex_unit_e     unit_i,
    input  logic [DATA_W-1:0]    alu_result_i,
    input  logic                 div_done_i,
    input  logic [DATA_W-1:0]    div_result_i,
    input  logic [31:0]          link_i,
    input  logic                 branch_redirect_i,
    input  logic [31:0]          branch_pc_i,
    input  ex_pkg::exc_cause_e   branch_exc_i,
    input  logic                 mem_done_i,
    input  logic [31:0]          mem_data_i,
    input  ex_pkg::exc_cause_e   mem_exc_i,
    input  logic                 result_ready_i,
    output logic                 result_valid_o,
    output logic [DATA_W-1:0]    result_o,
    output logic                 redirect_o,
    output logic [31:0]          redirect_pc_o,
    output ex_pkg::exc_cause_e   exc_cause_o,
    output logic                 retire_o
);
    import ex_pkg::*;

    logic complete;
    logic handoff;

    // combinational units finish in the start cycle
    always_comb begin
        case (unit_i)
            UNIT_DIV: complete = div_done_i;
            UNIT_MEM: complete = mem_done_i;
            default:  complete = start_i;
        endcase
    end

    assign handoff = result_valid_o && result_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            result_valid_o <= 1'b0;
            retire_o <= 1'b0;
        end else begin
            retire_o <= handoff;
            if (complete) begin
                result_valid_o <= 1'b1;
            end else if (handoff) begin
                result_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (complete) begin
            redirect_o <= (unit_i == UNIT_BRANCH) && branch_redirect_i;
            redirect_pc_o <= branch_pc_i;
            case (unit_i)
                UNIT_DIV: begin
                    result_o <= div_result_i;
                    exc_cause_o <= EXC_NONE;
                end
                UNIT_BRANCH: begin
                    result_o <= DATA_W'(link_i);
                    exc_cause_o <= branch_exc_i;
                end
                UNIT_MEM: begin
                    result_o <= DATA_W'(mem_data_i);
                    exc_cause_o <= mem_exc_i;
                end
                default: begin
                    result_o <= alu_result_i;
                    exc_cause_o <= EXC_NONE;
                end
            endcase
        end
    end

endmodule

// File: src/ex_stage.sv
`timescale 1ns/100ps

module ex_stage #(
    parameter int DATA_W = 32
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 issue_valid_i,
    input  ex_pkg::ex_op_e       op_i,
    input  logic [31:0]          pc_i,
    input  logic [31:0]          src1_i,
    input  logic [31:0]          src2_i,
    input  logic [31:0]          imm_i,
    input  logic                 pred_taken_i,
    input  logic [31:0]          pred_target_i,
    output logic                 issue_ready_o,
    output logic                 result_valid_o,
    output logic [DATA_W-1:0]    result_o,
    output logic                 redirect_o,
    output logic [31:0]          redirect_pc_o,
    output ex_pkg::exc_cause_e   exc_cause_o,
    input  logic                 result_ready_i,
    output logic                 wb_cyc_o,
    output logic                 wb_stb_o,
    output logic                 wb_we_o,
    output logic [29:0]          wb_adr_o,
    output logic [31:0]          wb_dat_o,
    output logic [3:0]           wb_sel_o,
    input  logic [31:0]          wb_dat_i,
    input  logic                 wb_ack_i
);
    import ex_pkg::*;

    logic              start;
    ex_unit_e          unit;
    ex_op_e            op;
    logic [31:0]       pc;
    logic [31:0]       src1;
    logic [31:0]       src2;
    logic [31:0]       imm;
    logic              pred_taken;
    logic [31:0]       pred_target;
    logic              retire;
    logic [DATA_W-1:0] alu_result;
    logic              div_done;
    logic [DATA_W-1:0] div_result;
    logic [31:0]       link;
    logic              br_redirect;
    logic [31:0]       br_pc;
    exc_cause_e        br_exc;
    logic              mem_done;
    logic [31:0]       mem_data;
    exc_cause_e        mem_exc;

    ex_decode u_decode (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid_i),
        .op_i          (op_i),
        .pc_i          (pc_i),
        .src1_i        (src1_i),
        .src2_i        (src2_i),
        .imm_i         (imm_i),
        .pred_taken_i  (pred_taken_i),
        .pred_target_i (pred_target_i),
        .retire_i      (retire),
        .issue_ready_o (issue_ready_o),
        .start_o       (start),
        .unit_o        (unit),
        .op_o          (op),
        .pc_o          (pc),
        .src1_o        (src1),
        .src2_o        (src2),
        .imm_o         (imm),
        .pred_taken_o  (pred_taken),
        .pred_target_o (pred_target)
    );

    int_alu #(.DATA_W(DATA_W)) u_alu (
        .op_i     (op),
        .pc_i     (pc),
        .a_i      (src1),
        .b_i      (src2),
        .imm_i    (imm),
        .result_o (alu_result)
    );

    iter_divider #(.DATA_W(DATA_W)) u_div (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .start_i    (start && (unit == UNIT_DIV)),
        .op_i       (op),
        .dividend_i (src1),
        .divisor_i  (src2),
        .done_o     (div_done),
        .result_o   (div_result)
    );

    branch_unit u_branch (
        .op_i          (op),
        .pc_i          (pc),
        .a_i           (src1),
        .b_i           (src2),
        .imm_i         (imm),
        .pred_taken_i  (pred_taken),
        .pred_target_i (pred_target),
        .link_o        (link),
        .redirect_o    (br_redirect),
        .redirect_pc_o (br_pc),
        .exc_cause_o   (br_exc)
    );

    lsu_wb_master u_lsu (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .start_i     (start && (unit == UNIT_MEM)),
        .op_i        (op),
        .base_i      (src1),
        .data_i      (src2),
        .imm_i       (imm),
        .wb_cyc_o    (wb_cyc_o),
        .wb_stb_o    (wb_stb_o),
        .wb_we_o     (wb_we_o),
        .wb_adr_o    (wb_adr_o),
        .wb_dat_o    (wb_dat_o),
        .wb_sel_o    (wb_sel_o),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_i    (wb_ack_i),
        .done_o      (mem_done),
        .load_data_o (mem_data),
        .exc_cause_o (mem_exc)
    );

    ex_result #(.DATA_W(DATA_W)) u_result (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .start_i           (start),
        .unit_i            (unit),
        .alu_result_i      (alu_result),
        .div_done_i        (div_done),
        .div_result_i      (div_result),
        .link_i            (link),
        .branch_redirect_i (br_redirect),
        .branch_pc_i       (br_pc),
        .branch_exc_i      (br_exc),
        .mem_done_i        (mem_done),
        .mem_data_i        (mem_data),
        .mem_exc_i         (mem_exc),
        .result_ready_i    (result_ready_i),
        .result_valid_o    (result_valid_o),
        .result_o          (result_o),
        .redirect_o        (redirect_o),
        .redirect_pc_o     (redirect_pc_o),
        .exc_cause_o       (exc_cause_o),
        .retire_o          (retire)
    );

endmodule

// File: verification/tb_ex_stage.sv
`timescale 1ns/100ps

module tb_ex_stage;
    import ex_pkg::*;

    localparam int DATA_W = 32;

    logic              clk;
    logic              rst_n_i;
    logic              issue_valid_i;
    ex_op_e            op_i;
    logic [31:0]       pc_i;
    logic [31:0]       src1_i;
    logic [31:0]       src2_i;
    logic [31:0]       imm_i;
    logic              pred_taken_i;
    logic [31:0]       pred_target_i;
    logic              issue_ready_o;
    logic              result_valid_o;
    logic [DATA_W-1:0] result_o;
    logic              redirect_o;
    logic [31:0]       redirect_pc_o;
    exc_cause_e        exc_cause_o;
    logic              result_ready_i;
    logic              wb_cyc_o;
    logic              wb_stb_o;
    logic              wb_we_o;
    logic [29:0]       wb_adr_o;
    logic [31:0]       wb_dat_o;
    logic [3:0]        wb_sel_o;
    logic [31:0]       wb_dat_i;
    logic              wb_ack_i;

    logic [31:0] mem [0:63];
    logic        stb_seen;
    int          stb_cycles;
    int          cyc_cycles;
    int          errors;
    int          failed;
    int          cycles;
    int          limit;
    int          seed;
    int          fd;
    string       line;
    string       trace_lines[$];

    ex_stage #(.DATA_W(DATA_W)) dut (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .issue_valid_i  (issue_valid_i),
        .op_i           (op_i),
        .pc_i           (pc_i),
        .src1_i         (src1_i),
        .src2_i         (src2_i),
        .imm_i          (imm_i),
        .pred_taken_i   (pred_taken_i),
        .pred_target_i  (pred_target_i),
        .issue_ready_o  (issue_ready_o),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .redirect_o     (redirect_o),
        .redirect_pc_o  (redirect_pc_o),
        .exc_cause_o    (exc_cause_o),
        .result_ready_i (result_ready_i),
        .wb_cyc_o       (wb_cyc_o),
        .wb_stb_o       (wb_stb_o),
        .wb_we_o        (wb_we_o),
        .wb_adr_o       (wb_adr_o),
        .wb_dat_o       (wb_dat_o),
        .wb_sel_o       (wb_sel_o),
        .wb_dat_i       (wb_dat_i),
        .wb_ack_i       (wb_ack_i)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("Regression failed");
            $finish;
        end
    end

    // wishbone slave acks one cycle after stb and writes with the ack
    always @(negedge clk) begin
        if (wb_cyc_o) begin
            cyc_cycles = cyc_cycles + 1;
        end
        if (wb_stb_o) begin
            stb_cycles = stb_cycles + 1;
        end
        if (wb_ack_i) begin
            wb_ack_i = 1'b0;
        end else if (wb_stb_o && stb_seen) begin
            stb_seen = 1'b0;
            wb_ack_i = 1'b1;
            if (wb_we_o) begin
                for (int b = 0; b < 4; b++) begin
                    if (wb_sel_o[b]) begin
                        mem[wb_adr_o[5:0]][8*b +: 8] = wb_dat_o[8*b +: 8];
                    end
                end
            end else begin
                wb_dat_i = mem[wb_adr_o[5:0]];
            end
        end else if (wb_stb_o) begin
            stb_seen = 1'b1;
        end
    end

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s %s: expected %08h, actual %08h", test, what, expected, actual);
            errors = errors + 1;
        end
    endtask

    task automatic run_test(input string text);
        string       name;
        logic [31:0] op_num;
        logic [31:0] pc;
        logic [31:0] s1;
        logic [31:0] s2;
        logic [31:0] imm;
        logic [31:0] pt;
        logic [31:0] ptgt;
        logic [31:0] exp_res;
        logic [31:0] exp_redir;
        logic [31:0] exp_rpc;
        logic [31:0] exp_exc;
        ex_op_e      op;
        int          fields;
        int          lat;
        int          exp_lat;
        int          exp_stb;
        int          stb_start;
        int          cyc_start;
        int          hold;
        int          errors_before;

        fields = $sscanf(text, "%s %d %h %h %h %h %d %h %h %d %h %d", name, op_num, pc,
                         s1, s2, imm, pt, ptgt, exp_res, exp_redir, exp_rpc, exp_exc);
        if (fields != 12) begin
            $display("Trace line could not be read: %s", text);
            failed = failed + 1;
        end else begin
            op = ex_op_e'(op_num[5:0]);
            exp_lat = 2;
            exp_stb = 0;
            if (op inside {OP_DIV, OP_DIVU, OP_MOD, OP_MODU}) begin
                exp_lat = DATA_W + 2;
            end else if ((op inside {OP_LDB, OP_LDBU, OP_LDH, OP_LDHU, OP_LDW,
                                     OP_STB, OP_STH, OP_STW}) &&
                         (exp_exc[1:0] != EXC_ALE)) begin
                // two stb cycles and the ack at edge 3 put valid at edge 4
                exp_lat = 4;
                exp_stb = 2;
            end
            errors_before = errors;
            stb_start = stb_cycles;
            cyc_start = cyc_cycles;
            issue_valid_i = 1'b1;
            op_i = op;
            pc_i = pc;
            src1_i = s1;
            src2_i = s2;
            imm_i = imm;
            pred_taken_i = pt[0];
            pred_target_i = ptgt;
            @(negedge clk);
            issue_valid_i = 1'b0;
            lat = 0;
            while (!result_valid_o) begin
                @(negedge clk);
                lat = lat + 1;
            end
            check_value(name, "latency", exp_lat, lat);
            hold = $unsigned($random(seed)) % 4;
            repeat (hold) begin
                @(negedge clk);
                check_value(name, "held valid", 32'd1, {31'd0, result_valid_o});
                check_value(name, "held result", exp_res, result_o);
                check_value(name, "issue ready", 32'd0, {31'd0, issue_ready_o});
            end
            check_value(name, "result", exp_res, result_o);
            check_value(name, "redirect", exp_redir, {31'd0, redirect_o});
            if (exp_redir[0]) begin
                check_value(name, "redirect pc", exp_rpc, redirect_pc_o);
            end
            check_value(name, "exception", exp_exc, {30'd0, exc_cause_o});
            check_value(name, "stb cycles", exp_stb, stb_cycles - stb_start);
            check_value(name, "cyc cycles", exp_stb, cyc_cycles - cyc_start);
            result_ready_i = 1'b1;
            @(negedge clk);
            result_ready_i = 1'b0;
            check_value(name, "valid after hand-off", 32'd0, {31'd0, result_valid_o});
            while (!issue_ready_o) begin
                @(negedge clk);
            end
            if (errors == errors_before) begin
                $display("test %-12s ok", name);
            end else begin
                failed = failed + 1;
                $display("test %-12s failed with %0d errors", name, errors - errors_before);
            end
        end
    endtask

    initial begin
        seed = 34854;
        errors = 0;
        failed = 0;
        cycles = 0;
        limit = 0;
        stb_cycles = 0;
        cyc_cycles = 0;
        stb_seen = 1'b0;
        rst_n_i = 1'b0;
        issue_valid_i = 1'b0;
        op_i = OP_NOP;
        pc_i = '0;
        src1_i = '0;
        src2_i = '0;
        imm_i = '0;
        pred_taken_i = 1'b0;
        pred_target_i = '0;
        result_ready_i = 1'b0;
        wb_dat_i = '0;
        wb_ack_i = 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = '0;
        end
        fd = $fopen("verification/ex_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file verification/ex_trace.txt");
            $display("Regression failed");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
                    trace_lines.push_back(line);
                end
            end
            $fclose(fd);
            limit = trace_lines.size() * (DATA_W + 12);
            repeat (3) @(posedge clk);
            @(negedge clk);
            rst_n_i = 1'b1;
            foreach (trace_lines[i]) begin
                run_test(trace_lines[i]);
            end
            $display("tests run %0d, passed %0d, failed %0d", trace_lines.size(),
                     trace_lines.size() - failed, failed);
            if (failed == 0 && trace_lines.size() > 0) begin
                $display("Regression passed");
            end else begin
                $display("Regression failed");
            end
            $finish;
        end
    end

endmodule

// File: verification/ex_trace.txt
# name op pc src1 src2 imm pred_taken pred_target result redirect redirect_pc exc
# op, pred_taken, redirect and exc are decimal (exc 0 none, 1 ALE, 2 ADEF), the rest hex
alu_add      1 00000000 00001234 00004321 00000000 0 00000000 00005555 0 00000000 0
alu_sub      2 00000000 00000005 00000007 00000000 0 00000000 fffffffe 0 00000000 0
alu_slt      3 00000000 ffffffff 00000001 00000000 0 00000000 00000001 0 00000000 0
alu_sltu     4 00000000 ffffffff 00000001 00000000 0 00000000 00000000 0 00000000 0
alu_nor      8 00000000 0f0f0000 000000f0 00000000 0 00000000 f0f0ff0f 0 00000000 0
alu_sra     11 00000000 80000010 00000004 00000000 0 00000000 f8000001 0 00000000 0
alu_pcadd   12 00001000 00000000 00000000 00000345 0 00000000 00346000 0 00000000 0
div_pos     13 00000000 00000064 00000007 00000000 0 00000000 0000000e 0 00000000 0
div_neg     13 00000000 ffffff9c fffffff9 00000000 0 00000000 0000000e 0 00000000 0
mod_neg_pos 15 00000000 ffffff9c 00000007 00000000 0 00000000 fffffffe 0 00000000 0
mod_pos_neg 15 00000000 00000064 fffffff9 00000000 0 00000000 00000002 0 00000000 0
divu        14 00000000 ffffff9c 00000007 00000000 0 00000000 24924916 0 00000000 0
modu        16 00000000 ffffff9c 00000007 00000000 0 00000000 00000002 0 00000000 0
div_zero    13 00000000 12345678 00000000 00000000 0 00000000 ffffffff 0 00000000 0
mod_zero    15 00000000 ffffff9c 00000000 00000000 0 00000000 ffffff9c 0 00000000 0
beq_hit     17 00000100 00000005 00000005 00000020 1 00000120 00000104 0 00000000 0
bne_miss    18 00000200 00000003 00000003 00000040 1 00000240 00000204 1 00000204 0
blt_target  19 00000300 ffffffff 00000001 fffffff0 1 00000310 00000304 1 000002f0 0
jirl_link   23 00000500 00001000 00000000 00000008 1 00001008 00000504 0 00000000 0
jirl_adef   23 00000600 00001002 00000000 00000000 1 00001004 00000604 0 00000000 2
st_word     31 00000000 00000040 8899aabb 00000000 0 00000000 00000000 0 00000000 0
st_byte     29 00000000 00000040 000000f1 00000005 0 00000000 00000000 0 00000000 0
st_half     30 00000000 00000040 00008234 00000006 0 00000000 00000000 0 00000000 0
ld_word     28 00000000 00000040 00000000 00000000 0 00000000 8899aabb 0 00000000 0
ld_byte     24 00000000 00000040 00000000 00000005 0 00000000 fffffff1 0 00000000 0
ld_byte_u   25 00000000 00000040 00000000 00000005 0 00000000 000000f1 0 00000000 0
ld_half     26 00000000 00000040 00000000 00000006 0 00000000 ffff8234 0 00000000 0
ld_half_u   27 00000000 00000040 00000000 00000006 0 00000000 00008234 0 00000000 0
ld_word_ale 28 00000000 00000040 00000000 00000002 0 00000000 00000000 0 00000000 1
st_half_ale 30 00000000 00000040 0000ffff 00000005 0 00000000 00000000 0 00000000 1
ld_word_chk 28 00000000 00000040 00000000 00000004 0 00000000 8234f100 0 00000000 0

// File: all.f
src/ex_pkg.sv
src/ex_decode.sv
src/int_alu.sv
src/iter_divider.sv
src/branch_unit.sv
src/lsu_wb_master.sv
src/ex_result.sv
src/ex_stage.sv
verification/tb_ex_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f all.f --top-module tb_ex_stage -o sim_ex_stage
sim_out=$(./obj_dir/sim_ex_stage)
echo "$sim_out"

if grep -qx "Regression passed" <<< "$sim_out"; then
    exit 0
fi
exit 1
